// File: sha_miner.f
sha_miner_pkg.sv
button_debounce.sv
sha256_schedule.sv
sha256_compress.sv
hash_sequencer.sv
op_stats.sv
sha_miner_top.sv
sha_miner_asserts.sv
sha_miner_tb.sv

// File: sha_miner_tb.sv
// Testbench for sha_miner_top with button stimulus, per-test checks, rate tracking and timeout
`timescale 1ns/1ps
`default_nettype none

module sha_miner_tb;

	localparam int TICKS          = 4;              // Clock ticks per ms
	localparam int SEC_CYCLES     = 1000 * TICKS;
	localparam int HASH_CYCLES    = 133;            // Start seen to digest_valid
	localparam int PRESS_CYCLES   = 10 * TICKS;     // Short press, about 10 ms
	localparam int HOLD_CYCLES    = 2000 * TICKS;
	localparam int SETTLE         =
		(sha_miner_pkg::PULSE_END_MS + sha_miner_pkg::RELEASE_MS) * TICKS + 40;
	localparam int HOLD_MIN       =
		(HOLD_CYCLES - sha_miner_pkg::LONG_MS * TICKS) / HASH_CYCLES - 1;
	localparam int TIMEOUT_CYCLES = 40000;          // Run needs about 13k cycles

	logic                   clk;
	logic                   reset;
	logic                   fire_button;
	logic                   busy;
	logic                   digest_valid;
	sha_miner_pkg::digest_t hash;
	sha_miner_pkg::stats_t  stats;

	int errors       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int pulses       = 0;  // digest_valid pulses so far
	int rate_bad     = 0;  // Rate mismatches inside the hold
	int hold_checks  = 0;  // Second boundaries inside the hold
	int hold_rate_max = 0;
	int cycles       = 0;
	logic in_hold    = 1'b0;
	int e0;
	int r0;
	int p0;
	bit seen;
	bit ok;
	sha_miner_pkg::op_count_t count0;

	sha_miner_top #(.ticks_per_ms(TICKS)) uut (
		.clk(clk), .reset(reset), .fire_button(fire_button), .busy(busy),
		.hash(hash), .digest_valid(digest_valid), .stats(stats)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// Hard stop
	always @(posedge clk) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// op_count steps by one the cycle after each digest_valid
	count_step: assert property (@(posedge clk) disable iff (reset)
		digest_valid |=> stats.op_count == $past(stats.op_count) + 1)
		else report_mismatch("op_count did not step after digest_valid");

	task automatic report_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t ns: %s", $time, msg);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input bit pass);
		tests_run++;
		if (!pass) tests_failed++;
		$display("test %0d %-18s %s", tests_run, name, pass ? "pass" : "FAIL");
	endtask

	// Called on a falling edge; button high for len cycles
	task automatic press_button(input int len);
		fire_button = 1'b1;
		repeat (len) @(negedge clk);
		fire_button = 1'b0;
	endtask

	task automatic wait_digest(input int limit, output bit got);
		int n;
		got = 1'b0;
		n = 0;
		while (!got && n < limit) begin
			@(negedge clk);
			n++;
			if (digest_valid) got = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Digest, busy and per-second rate checks on falling edge samples
	task automatic watch_outputs();
		int cyc;
		int win;
		int closed;
		bit busy_q;  // busy one falling edge earlier
		cyc = 0;
		win = 0;
		closed = 0;
		busy_q = 1'b0;
		forever begin
			if (cyc > 0 && cyc % SEC_CYCLES == 0) begin  // Rate latched one posedge ago
				assert (stats.ops_per_sec == closed) else begin
					report_mismatch($sformatf("ops_per_sec %0d, counted %0d",
						stats.ops_per_sec, closed));
					if (in_hold) rate_bad++;
				end
				if (in_hold) begin
					hold_checks++;
					if (closed > hold_rate_max) hold_rate_max = closed;
				end
			end
			if (digest_valid) begin
				pulses++;
				assert (hash == sha_miner_pkg::EXPECTED_DIGEST)
					else report_mismatch($sformatf("hash %h", hash));
				assert (busy_q) else report_mismatch("busy low while the second block ran");
			end
			if ((cyc + 1) % SEC_CYCLES == 0) begin  // Pulse here opens the next window
				closed = win;
				win = digest_valid;
			end else begin
				win += digest_valid;
			end
			busy_q = busy;
			@(negedge clk);
			cyc++;
		end
	endtask

	initial begin
		void'($urandom(32'h4ea24d38));
		reset = 1'b1;
		fire_button = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		fork
			watch_outputs();
		join_none

		// Reset values
		e0 = errors;
		@(negedge clk);
		assert (busy == 1'b0 && digest_valid == 1'b0)
			else report_mismatch("busy or digest_valid set after reset");
		assert (hash == '0) else report_mismatch("hash not cleared by reset");
		assert (stats == '0) else report_mismatch("stats not cleared by reset");
		end_test("reset state", errors == e0);

		// Bounces shorter than PRESS_MS
		e0 = errors;
		p0 = pulses;
		repeat (6) begin
			press_button($urandom_range(1, sha_miner_pkg::PRESS_MS * TICKS / 2));
			repeat ($urandom_range(20, 60)) @(negedge clk);
		end
		repeat (HASH_CYCLES + 40) @(negedge clk);
		assert (pulses == p0) else report_mismatch("digest_valid after a glitch");
		end_test("glitch rejection", errors == e0);

		// One short press gives one hash
		e0 = errors;
		p0 = pulses;
		press_button(PRESS_CYCLES);
		wait_digest(HASH_CYCLES + 80, seen);
		if (!seen) report_failure("no digest_valid after a short press");
		assert (hash == sha_miner_pkg::EXPECTED_DIGEST) else report_mismatch("short press digest");
		repeat (SETTLE) @(negedge clk);
		assert (pulses == p0 + 1)
			else report_mismatch($sformatf("%0d digests for one press", pulses - p0));
		assert (stats.op_count == 1) else report_mismatch("op_count not 1 after first hash");
		assert (busy == 1'b0) else report_mismatch("busy still high after the hash");
		end_test("short press", errors == e0);

		// Separated presses with random gaps past the release wait
		e0 = errors;
		p0 = pulses;
		repeat (3) begin
			count0 = stats.op_count;
			press_button(PRESS_CYCLES);
			wait_digest(HASH_CYCLES + 80, seen);
			if (!seen) report_failure("no digest_valid for one of the separated presses");
			@(negedge clk);
			assert (stats.op_count == count0 + 1) else report_mismatch("op_count step not one");
			repeat ($urandom_range(SETTLE, SETTLE + 300)) @(negedge clk);
		end
		assert (pulses == p0 + 3) else report_mismatch("wrong digest count for three presses");
		end_test("separated presses", errors == e0);

		// Long hold with the rate model running alongside
		e0 = errors;
		r0 = rate_bad;
		p0 = pulses;
		in_hold <= 1'b1;
		press_button(HOLD_CYCLES);
		in_hold <= 1'b0;
		repeat (sha_miner_pkg::RELEASE_MS * TICKS + HASH_CYCLES + 40) @(negedge clk);
		if (pulses - p0 < HOLD_MIN)
			report_failure($sformatf("only %0d digests during the hold", pulses - p0));
		p0 = pulses;
		repeat (SETTLE) @(negedge clk);
		assert (pulses == p0) else report_mismatch("digest_valid after the release wait");
		end_test("long hold", errors - e0 == rate_bad - r0);
		ok = hold_checks > 0 && hold_rate_max > 0;
		if (!ok) report_failure("no second boundary with hashes during the hold");
		end_test("rate per second", ok && rate_bad == r0);

		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, errors, uut.checks.fail_count);
		if (tests_failed == 0 && errors == 0 && uut.checks.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sha_miner_asserts.sv
// Invariant assertions on the sha_miner_top outputs and their bind
`timescale 1ns/1ps
`default_nettype none

module sha_miner_asserts (
	input wire                         clk,
	input wire                         reset,
	input wire                         digest_valid,
	input wire sha_miner_pkg::digest_t hash,
	input wire sha_miner_pkg::stats_t  stats
);

	int unsigned fail_count = 0;  // Failed assertions, read by the testbench

	// Every finished hash is the FIPS digest
	digest_ok: assert property (@(posedge clk) disable iff (reset)
		digest_valid |-> hash == sha_miner_pkg::EXPECTED_DIGEST)
		else begin
			$error("digest differs from the expected value");
			fail_count++;
		end

	// Total never goes backwards
	count_monotonic: assert property (@(posedge clk) disable iff (reset)
		stats.op_count >= $past(stats.op_count))
		else begin
			$error("op_count decreased");
			fail_count++;
		end

	// Two blocks per hash, so pulses are far apart
	pulse_single: assert property (@(posedge clk) disable iff (reset)
		digest_valid |=> !digest_valid)
		else begin
			$error("digest_valid high in two consecutive cycles");
			fail_count++;
		end

endmodule

bind sha_miner_top sha_miner_asserts checks (
	.clk(clk), .reset(reset), .digest_valid(digest_valid), .hash(hash), .stats(stats)
);

`default_nettype wire

// File: sha_miner_top.sv
// Top level joining debounce, sequencer, SHA-256 core and statistics
`timescale 1ns/1ps
`default_nettype none

module sha_miner_top #(
	parameter int ticks_per_ms = 48000
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    fire_button,
	output logic                   busy,
	output sha_miner_pkg::digest_t hash,
	output logic                   digest_valid,
	output sha_miner_pkg::stats_t  stats
);

	logic                      press;
	logic                      hold;
	logic                      block_done;
	sha_miner_pkg::block_req_t req;
	sha_miner_pkg::digest_t    digest;  // Running chain from the core

	button_debounce #(.ticks_per_ms(ticks_per_ms)) debounce (
		.clk(clk), .reset(reset), .button(fire_button), .press(press), .hold(hold)
	);

	hash_sequencer sequencer (
		.clk(clk), .reset(reset), .press(press), .hold(hold),
		.block_done(block_done), .digest(digest), .req(req),
		.busy(busy), .hash(hash), .digest_valid(digest_valid)
	);

	sha256_compress core (
		.clk(clk), .reset(reset), .req(req), .block_done(block_done), .digest(digest)
	);

	op_stats #(.ticks_per_ms(ticks_per_ms)) statistics (
		.clk(clk), .reset(reset), .digest_valid(digest_valid), .stats(stats)
	);

endmodule

`default_nettype wire

// File: op_stats.sv
// Total operation counter, one-second timebase and per-second rate latch
`timescale 1ns/1ps
`default_nettype none

module op_stats #(
	parameter int ticks_per_ms = 48000
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   digest_valid,
	output sha_miner_pkg::stats_t stats
);

	localparam int SEC_TICKS = 1000 * ticks_per_ms;
	localparam int CW = $clog2(SEC_TICKS);

	logic [CW-1:0]        sec_cnt;     // Timebase
	logic                 sec_wrap;
	sha_miner_pkg::rate_t window_cnt;  // Hashes in the current second

	assign sec_wrap = (sec_cnt == CW'(SEC_TICKS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			sec_cnt <= '0;
		end else begin
			sec_cnt <= sec_wrap ? '0 : sec_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Counters
	always_ff @(posedge clk) begin
		if (reset) begin
			stats      <= '0;
			window_cnt <= '0;
		end else begin
			if (digest_valid) stats.op_count <= stats.op_count + 1'b1;
			if (sec_wrap) begin
				stats.ops_per_sec <= window_cnt;
				window_cnt        <= digest_valid ? 24'd1 : 24'd0;  // Opens the new window
			end else if (digest_valid) begin
				window_cnt <= window_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hash_sequencer.sv
// Start detection, two-block feed FSM and digest latch
`timescale 1ns/1ps
`default_nettype none

module hash_sequencer (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             press,
	input  wire                             hold,
	input  wire                             block_done,
	input  wire sha_miner_pkg::digest_t     digest,
	output sha_miner_pkg::block_req_t       req,
	output logic                            busy,
	output sha_miner_pkg::digest_t          hash,
	output logic                            digest_valid  // One cycle per hash
);

	sha_miner_pkg::seq_state_t state;
	logic press_q;  // For the press rising edge
	logic start;
	logic hash_done;

	// Short press edge, or keep going while held
	assign start     = (press && !press_q) || hold;
	assign hash_done = (state == sha_miner_pkg::seq_wait_second) && block_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			press_q <= 1'b0;
		end else begin
			press_q <= press;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Block feed
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sha_miner_pkg::seq_idle;
		end else begin
			case (state)
				sha_miner_pkg::seq_idle:         // Also re-samples start after digest_valid
					if (start) state <= sha_miner_pkg::seq_run_first;
				sha_miner_pkg::seq_run_first:
					state <= sha_miner_pkg::seq_wait_first;
				sha_miner_pkg::seq_wait_first:
					if (block_done) state <= sha_miner_pkg::seq_run_second;
				sha_miner_pkg::seq_run_second:
					state <= sha_miner_pkg::seq_wait_second;
				sha_miner_pkg::seq_wait_second:
					if (block_done) state <= sha_miner_pkg::seq_idle;
				default:
					state <= sha_miner_pkg::seq_idle;
			endcase
		end
	end

	// Request strobes straight from state
	assign req.valid = (state == sha_miner_pkg::seq_run_first) ||
	                   (state == sha_miner_pkg::seq_run_second);
	assign req.first = (state == sha_miner_pkg::seq_run_first);
	assign req.data  = req.first ? sha_miner_pkg::MSG_BLOCK0 : sha_miner_pkg::MSG_BLOCK1;
	assign busy      = (state != sha_miner_pkg::seq_idle);

	// Digest latch
	always_ff @(posedge clk) begin
		if (reset) begin
			hash         <= '0;
			digest_valid <= 1'b0;
		end else begin
			digest_valid <= hash_done;
			if (hash_done) hash <= digest;  // Final chained value
		end
	end

endmodule

`default_nettype wire

// File: sha256_compress.sv
// SHA-256 compression core with round state, chaining add and block-done strobe
`timescale 1ns/1ps
`default_nettype none

module sha256_compress (
	input  wire                            clk,
	input  wire                            reset,
	input  wire sha_miner_pkg::block_req_t req,
	output logic                           block_done,  // One cycle, N+65
	output sha_miner_pkg::digest_t         digest
);

	sha_miner_pkg::word_t a, b, c, d, e, f, g, h;  // Working registers
	sha_miner_pkg::digest_t chain;                 // Chaining hash H0..H7
	sha_miner_pkg::digest_t seed;
	sha_miner_pkg::digest_t work_next;
	sha_miner_pkg::round_t  round;
	logic                   busy;
	logic                   accept;
	logic                   last_round;
	sha_miner_pkg::word_t   w;
	sha_miner_pkg::word_t   t1;
	sha_miner_pkg::word_t   t2;

	// Sigma0, rotr 2 ^ rotr 13 ^ rotr 22
	function automatic sha_miner_pkg::word_t bsig0(input sha_miner_pkg::word_t x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	// Sigma1, rotr 6 ^ rotr 11 ^ rotr 25
	function automatic sha_miner_pkg::word_t bsig1(input sha_miner_pkg::word_t x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	sha256_schedule schedule (
		.clk     (clk),
		.load    (accept),
		.block   (req.data),
		.advance (busy),
		.w       (w)
	);

	assign accept     = req.valid && !busy;  // Sequencer only asks while idle
	assign last_round = busy && (round == 6'd63);
	assign seed       = req.first ? sha_miner_pkg::HASH_INIT : chain;

	//////////////////////////////////////////////////////////////////////
	// One round per cycle
	assign t1 = h + bsig1(e) + ((e & f) ^ (~e & g)) + sha_miner_pkg::ROUND_K[round] + w;
	assign t2 = bsig0(a) + ((a & b) ^ (a & c) ^ (b & c));
	assign work_next = {t1 + t2, a, b, c, d + t1, e, f, g};

	// Working registers, payload only
	always_ff @(posedge clk) begin
		if (accept) begin
			{a, b, c, d, e, f, g, h} <= seed;
		end else if (busy) begin
			{a, b, c, d, e, f, g, h} <= work_next;
		end
	end

	// Round counter and busy flag
	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			round      <= '0;
			block_done <= 1'b0;
		end else begin
			block_done <= last_round;
			if (accept) begin
				busy  <= 1'b1;
				round <= '0;
			end else if (busy) begin
				round <= round + 1'b1;  // Wraps to 0 after round 63
				if (last_round) busy <= 1'b0;
			end
		end
	end

	// Chaining hash, seeded on accept and summed after round 63
	always_ff @(posedge clk) begin
		if (reset) begin
			chain <= '0;
		end else if (accept) begin
			chain <= seed;
		end else if (last_round) begin
			for (int i = 0; i < 8; i++) begin
				chain[255 - 32*i -: 32] <= chain[255 - 32*i -: 32] + work_next[255 - 32*i -: 32];
			end
		end
	end

	assign digest = chain;

endmodule

`default_nettype wire

// File: sha256_schedule.sv
// SHA-256 message schedule, 16-word sliding window giving one word per round
`timescale 1ns/1ps
`default_nettype none

module sha256_schedule (
	input  wire                        clk,
	input  wire                        load,     // Copy a new block in
	input  wire sha_miner_pkg::block_t block,
	input  wire                        advance,  // Step to the next round
	output sha_miner_pkg::word_t       w         // W for the current round
);

	sha_miner_pkg::word_t win [16];  // win[0] is W_t
	sha_miner_pkg::word_t w_next;

	// sigma0, rotr 7 ^ rotr 18 ^ shr 3
	function automatic sha_miner_pkg::word_t ssig0(input sha_miner_pkg::word_t x);
		return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
	endfunction

	// sigma1, rotr 17 ^ rotr 19 ^ shr 10
	function automatic sha_miner_pkg::word_t ssig1(input sha_miner_pkg::word_t x);
		return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
	endfunction

	// W_t+16 from W_t+14, W_t+9, W_t+1, W_t
	assign w_next = ssig1(win[14]) + win[9] + ssig0(win[1]) + win[0];

	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < 16; i++) begin
				win[i] <= block[511 - 32*i -: 32];  // Word 0 from the top bits
			end
		end else if (advance) begin
			for (int i = 0; i < 15; i++) begin
				win[i] <= win[i+1];
			end
			win[15] <= w_next;
		end
	end

	assign w = win[0];

endmodule

`default_nettype wire

// File: button_debounce.sv
// Fire button synchronizer and press/hold debounce FSM
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
	parameter int ticks_per_ms = 48000
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  button,
	output logic press,  // High for the pulse window
	output logic hold    // High while long-held, through the release wait
);

	// Thresholds in clock ticks
	localparam int PRESS_TICKS     = sha_miner_pkg::PRESS_MS * ticks_per_ms;
	localparam int PULSE_END_TICKS = sha_miner_pkg::PULSE_END_MS * ticks_per_ms;
	localparam int LONG_TICKS      = sha_miner_pkg::LONG_MS * ticks_per_ms;
	localparam int RELEASE_TICKS   = sha_miner_pkg::RELEASE_MS * ticks_per_ms;
	localparam int SW = $clog2(LONG_TICKS + 1);     // Since-press counter width
	localparam int OW = $clog2(RELEASE_TICKS + 1);  // Released counter width

	logic [2:0] sync_q;    // Three flops against metastability
	logic       btn;
	logic [SW-1:0] since_cnt;
	logic [OW-1:0] off_cnt;
	sha_miner_pkg::debounce_state_t state;

	assign btn = sync_q[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[1:0], button};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Press/hold FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sha_miner_pkg::db_idle;
		end else begin
			case (state)
				sha_miner_pkg::db_idle:
					if (btn) state <= sha_miner_pkg::db_wait_press;
				sha_miner_pkg::db_wait_press:  // Must stay high for PRESS_MS
					if (!btn) state <= sha_miner_pkg::db_idle;
					else if (since_cnt == SW'(PRESS_TICKS)) state <= sha_miner_pkg::db_pulse;
				sha_miner_pkg::db_pulse:       // Fixed window, input ignored
					if (since_cnt == SW'(PULSE_END_TICKS)) state <= sha_miner_pkg::db_wait_long;
				sha_miner_pkg::db_wait_long:
					if (!btn) state <= sha_miner_pkg::db_wait_off;
					else if (since_cnt >= SW'(LONG_TICKS)) state <= sha_miner_pkg::db_long_hold;
				sha_miner_pkg::db_long_hold:
					if (!btn) state <= sha_miner_pkg::db_wait_long_off;
				sha_miner_pkg::db_wait_off:    // Re-press resumes the wait
					if (btn) state <= sha_miner_pkg::db_wait_long;
					else if (off_cnt == OW'(RELEASE_TICKS)) state <= sha_miner_pkg::db_idle;
				sha_miner_pkg::db_wait_long_off:
					if (btn) state <= sha_miner_pkg::db_long_hold;
					else if (off_cnt == OW'(RELEASE_TICKS)) state <= sha_miner_pkg::db_idle;
				default:
					state <= sha_miner_pkg::db_idle;
			endcase
		end
	end

	// Counters
	always_ff @(posedge clk) begin
		if (reset) begin
			since_cnt <= '0;
			off_cnt   <= '0;
		end else begin
			if (state == sha_miner_pkg::db_idle)
				since_cnt <= '0;
			else if (since_cnt != SW'(LONG_TICKS))  // Saturate on long holds
				since_cnt <= since_cnt + 1'b1;
			if (state == sha_miner_pkg::db_wait_off || state == sha_miner_pkg::db_wait_long_off)
				off_cnt <= off_cnt + 1'b1;
			else
				off_cnt <= '0;                     // Low time only
		end
	end

	assign press = (state == sha_miner_pkg::db_pulse);
	assign hold  = (state == sha_miner_pkg::db_long_hold) ||
	               (state == sha_miner_pkg::db_wait_long_off);

endmodule

`default_nettype wire

// File: sha_miner_pkg.sv
// Widths, typedefs, request and statistics structs, FSM encodings and SHA-256 constants
`default_nettype none

package sha_miner_pkg;

	typedef logic [31:0]  word_t;      // One SHA-256 word
	typedef logic [511:0] block_t;     // Padded message block, word 0 in the top bits
	typedef logic [255:0] digest_t;    // H0 in the top bits
	typedef logic [47:0]  op_count_t;
	typedef logic [23:0]  rate_t;
	typedef logic [5:0]   round_t;     // 0..63

	// Block request toward the core
	typedef struct packed {
		logic   valid;  // Single-cycle strobe
		logic   first;  // Seed from HASH_INIT
		block_t data;
	} block_req_t;

	typedef struct packed {
		op_count_t op_count;
		rate_t     ops_per_sec;
	} stats_t;

	// Fire button debounce FSM
	typedef enum logic [2:0] {
		db_idle, db_wait_press, db_pulse, db_wait_long,
		db_long_hold, db_wait_off, db_wait_long_off
	} debounce_state_t;

	// Two-block feed FSM
	typedef enum logic [2:0] {
		seq_idle, seq_run_first, seq_wait_first, seq_run_second, seq_wait_second
	} seq_state_t;

	// Button timing in milliseconds
	localparam int PRESS_MS     = 5;
	localparam int PULSE_END_MS = 25;
	localparam int LONG_MS      = 700;
	localparam int RELEASE_MS   = 100;

	//////////////////////////////////////////////////////////////////////
	// FIPS 180-4 constants
	localparam word_t ROUND_K [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam digest_t HASH_INIT = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq" plus the 0x80 pad byte
	localparam block_t MSG_BLOCK0 = {
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
	};
	localparam block_t MSG_BLOCK1 = {480'h0, 32'h000001c0}; // Zero pad, 448-bit length

	localparam digest_t EXPECTED_DIGEST = {
		32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
		32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
	};

endpackage

`default_nettype wire
